/* Bender.yml */
package:
  name: line_adapter

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/line_pkg.sv
      - design/line_arbiter.sv
      - design/next_line_prefetcher.sv
      - design/burst_serdes.sv
      - design/line_adapter_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - sim/burst_mem_model.sv
      - sim/tb_line_adapter.sv

/* design/burst_serdes.sv */
`timescale 1ns/1ns
`include "line_consts.svh"

module burst_serdes (
  input  logic            clk,
  input  logic            rst,
  input  logic            start,
  input  line_pkg::addr_t addr,
  input  logic            write,
  input  line_pkg::line_t wline,
  output logic            done,
  output line_pkg::line_t rline,
  output line_pkg::addr_t bmem_addr,
  output logic            bmem_read,
  output logic            bmem_write,
  output line_pkg::beat_t bmem_wdata,
  input  logic            bmem_ready,
  input  line_pkg::beat_t bmem_rdata,
  input  logic            bmem_rvalid
);
  import line_pkg::*;

  localparam beat_idx_t LAST_BEAT = beat_idx_t'(`LINE_BEATS - 1);

  serdes_state_t state;
  beat_idx_t     beat_cnt;
  logic          read_issue;   // Single-cycle read strobe.
  addr_t         addr_q;
  line_t         wline_q;
  line_t         rline_q;
  logic          take_beat;

  assign take_beat = bmem_rvalid && (state == SD_WAIT || state == SD_READ);

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= SD_IDLE;
      beat_cnt   <= '0;
      read_issue <= 1'b0;
    end else begin
      read_issue <= 1'b0;
      unique case (state)
        SD_IDLE: begin
          if (start) begin
            beat_cnt <= '0;
            if (write) begin
              state <= SD_WRITE;
            end else begin
              state      <= SD_WAIT;
              read_issue <= 1'b1;
            end
          end
        end

        SD_WRITE: begin
          if (bmem_ready) begin   // Beat accepted.
            beat_cnt <= beat_cnt + 1'b1;
            if (beat_cnt == LAST_BEAT) begin
              state <= SD_DONE;
            end
          end
        end

        SD_WAIT: begin
          if (bmem_rvalid) begin
            beat_cnt <= beat_cnt + 1'b1;
            state    <= SD_READ;
          end
        end

        SD_READ: begin
          // Gaps in rvalid just hold the count.
          if (bmem_rvalid) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (beat_cnt == LAST_BEAT) begin
              state <= SD_DONE;
            end
          end
        end

        SD_DONE: state <= SD_IDLE;

        default: state <= SD_IDLE;
      endcase
    end
  end

  // Command and line data.
  always_ff @(posedge clk) begin
    if (state == SD_IDLE && start) begin
      addr_q  <= addr;
      wline_q <= wline;
    end
    if (take_beat) begin
      rline_q[beat_cnt*`BEAT_W +: `BEAT_W] <= bmem_rdata;
    end
  end

  assign bmem_addr  = addr_q;
  assign bmem_read  = read_issue;
  assign bmem_write = (state == SD_WRITE);
  assign bmem_wdata = wline_q[beat_cnt*`BEAT_W +: `BEAT_W];   // Held while ready is low.
  assign done       = (state == SD_DONE);
  assign rline      = rline_q;

  a_rw_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(bmem_read && bmem_write))
    else $error("Read and write strobes together on the memory bus.");

  // Memory must not return data that was never asked for.
  a_rvalid_expected: assert property (@(posedge clk) disable iff (rst)
    bmem_rvalid |-> (state inside {SD_WAIT, SD_READ}))
    else $error("Read beat outside a read burst.");

endmodule

/* design/line_adapter_top.sv */
`timescale 1ns/1ns

module line_adapter_top (
  input  logic            clk,
  input  logic            rst,
  input  logic            icache_read,
  input  line_pkg::addr_t icache_addr,
  output line_pkg::line_t icache_rdata,
  output logic            icache_resp,
  input  logic            dcache_read,
  input  logic            dcache_write,
  input  line_pkg::addr_t dcache_addr,
  input  line_pkg::line_t dcache_wdata,
  output line_pkg::line_t dcache_rdata,
  output logic            dcache_resp,
  output line_pkg::addr_t bmem_addr,
  output logic            bmem_read,
  output logic            bmem_write,
  output line_pkg::beat_t bmem_wdata,
  input  logic            bmem_ready,
  input  line_pkg::beat_t bmem_rdata,
  input  logic            bmem_rvalid
);
  import line_pkg::*;

  // Prefetcher side.
  logic  pf_req, pf_hit;
  addr_t pf_addr;
  line_t pf_line;
  logic  icache_miss_grant, pf_grant, hit_served, line_done, wr_grant;

  // Serdes command and completion.
  logic  start, write, done;
  addr_t addr;
  line_t wline, rline;

  line_arbiter u_arbiter (
    .clk               (clk),
    .rst               (rst),
    .icache_read       (icache_read),
    .icache_addr       (icache_addr),
    .icache_rdata      (icache_rdata),
    .icache_resp       (icache_resp),
    .dcache_read       (dcache_read),
    .dcache_write      (dcache_write),
    .dcache_addr       (dcache_addr),
    .dcache_wdata      (dcache_wdata),
    .dcache_rdata      (dcache_rdata),
    .dcache_resp       (dcache_resp),
    .pf_req            (pf_req),
    .pf_addr           (pf_addr),
    .pf_hit            (pf_hit),
    .pf_line           (pf_line),
    .icache_miss_grant (icache_miss_grant),
    .pf_grant          (pf_grant),
    .hit_served        (hit_served),
    .line_done         (line_done),
    .wr_grant          (wr_grant),
    .start             (start),
    .addr              (addr),
    .write             (write),
    .wline             (wline),
    .done              (done),
    .rline             (rline)
  );

  next_line_prefetcher u_prefetcher (
    .clk               (clk),
    .rst               (rst),
    .icache_addr       (icache_addr),
    .icache_miss_grant (icache_miss_grant),
    .pf_grant          (pf_grant),
    .hit_served        (hit_served),
    .line_done         (line_done),
    .rline             (rline),
    .wr_grant          (wr_grant),
    .write_addr        (addr),   // Command address carries the write target.
    .pf_req            (pf_req),
    .pf_addr           (pf_addr),
    .pf_hit            (pf_hit),
    .pf_line           (pf_line)
  );

  burst_serdes u_serdes (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .addr        (addr),
    .write       (write),
    .wline       (wline),
    .done        (done),
    .rline       (rline),
    .bmem_addr   (bmem_addr),
    .bmem_read   (bmem_read),
    .bmem_write  (bmem_write),
    .bmem_wdata  (bmem_wdata),
    .bmem_ready  (bmem_ready),
    .bmem_rdata  (bmem_rdata),
    .bmem_rvalid (bmem_rvalid)
  );

endmodule

/* design/line_arbiter.sv */
`timescale 1ns/1ns

module line_arbiter (
  input  logic            clk,
  input  logic            rst,
  input  logic            icache_read,
  input  line_pkg::addr_t icache_addr,
  output line_pkg::line_t icache_rdata,
  output logic            icache_resp,
  input  logic            dcache_read,
  input  logic            dcache_write,
  input  line_pkg::addr_t dcache_addr,
  input  line_pkg::line_t dcache_wdata,
  output line_pkg::line_t dcache_rdata,
  output logic            dcache_resp,
  input  logic            pf_req,
  input  line_pkg::addr_t pf_addr,
  input  logic            pf_hit,
  input  line_pkg::line_t pf_line,
  output logic            icache_miss_grant,
  output logic            pf_grant,
  output logic            hit_served,
  output logic            line_done,
  output logic            wr_grant,
  output logic            start,
  output line_pkg::addr_t addr,
  output logic            write,
  output line_pkg::line_t wline,
  input  logic            done,
  input  line_pkg::line_t rline
);
  import line_pkg::*;

  arb_state_t state, state_next;
  owner_t     owner, owner_next;
  logic       rr_dcache, rr_dcache_next;   // Data cache wins the next tie.
  logic       icache_req, dcache_req;
  logic       pick_icache, pick_dcache, pick_pf;

  assign icache_req  = icache_read;
  assign dcache_req  = dcache_read | dcache_write;
  assign pick_icache = icache_req & (~rr_dcache | ~dcache_req);
  assign pick_dcache = dcache_req & ~pick_icache;
  // Prefetch only gets a quiet bus.
  assign pick_pf     = pf_req & ~icache_req & ~dcache_req;

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= ARB_IDLE;
      owner     <= OWN_ICACHE;
      rr_dcache <= 1'b0;
    end else begin
      state     <= state_next;
      owner     <= owner_next;
      rr_dcache <= rr_dcache_next;
    end
  end

  always_comb begin
    state_next        = state;
    owner_next        = owner;
    rr_dcache_next    = rr_dcache;
    start             = 1'b0;
    addr              = icache_addr;
    write             = 1'b0;
    wline             = dcache_wdata;   // Only the data cache writes.
    icache_miss_grant = 1'b0;
    pf_grant          = 1'b0;
    hit_served        = 1'b0;
    line_done         = 1'b0;
    wr_grant          = 1'b0;
    icache_resp       = 1'b0;
    dcache_resp       = 1'b0;
    icache_rdata      = rline;
    dcache_rdata      = rline;

    unique case (state)
      ARB_IDLE: begin
        if (pick_icache) begin
          rr_dcache_next = 1'b1;
          owner_next     = OWN_ICACHE;
          if (pf_hit) begin
            state_next = ARB_HIT;   // Answer from the buffer, bus stays idle.
          end else begin
            start             = 1'b1;
            icache_miss_grant = 1'b1;
            state_next        = ARB_BUSY;
          end
        end else if (pick_dcache) begin
          rr_dcache_next = 1'b0;
          owner_next     = OWN_DCACHE;
          start          = 1'b1;
          addr           = dcache_addr;
          write          = dcache_write;
          wr_grant       = dcache_write;
          state_next     = ARB_BUSY;
        end else if (pick_pf) begin
          owner_next = OWN_PREFETCH;
          start      = 1'b1;
          addr       = pf_addr;
          pf_grant   = 1'b1;
          state_next = ARB_BUSY;
        end
      end

      ARB_BUSY: begin
        if (done) begin
          // Route the completion to whoever started it.
          unique case (owner)
            OWN_ICACHE:   icache_resp = 1'b1;
            OWN_DCACHE:   dcache_resp = 1'b1;
            OWN_PREFETCH: line_done   = 1'b1;
            default:      line_done   = 1'b0;
          endcase
          state_next = ARB_IDLE;
        end
      end

      ARB_HIT: begin
        icache_resp  = 1'b1;
        icache_rdata = pf_line;
        hit_served   = 1'b1;
        state_next   = ARB_IDLE;
      end

      default: state_next = ARB_IDLE;
    endcase
  end

  // A completion must belong to a command started from here.
  a_done_when_busy: assert property (@(posedge clk) disable iff (rst)
    done |-> (state == ARB_BUSY))
    else $error("Serdes completion with no command outstanding.");

endmodule

/* design/line_consts.svh */
`ifndef LINE_CONSTS_SVH
`define LINE_CONSTS_SVH

// Byte address width.
`define LINE_ADDR_W 32

// One cache line.
`define LINE_W 256

// One memory bus beat.
`define BEAT_W 64

`define LINE_BEATS 4   // Beats per line, lowest first.

`define LINE_OFFSET_W 5   // Byte offset bits inside a line.

`endif

/* design/line_pkg.sv */
`include "line_consts.svh"

package line_pkg;

  typedef logic [`LINE_ADDR_W-1:0] addr_t;   // Byte address.
  typedef logic [`LINE_W-1:0]      line_t;
  typedef logic [`BEAT_W-1:0]      beat_t;

  // Line number, address without the offset bits.
  typedef logic [`LINE_ADDR_W-`LINE_OFFSET_W-1:0] line_tag_t;

  typedef logic [$clog2(`LINE_BEATS)-1:0] beat_idx_t;

  // Who holds the bus or the reply.
  typedef enum logic [1:0] {
    OWN_ICACHE,
    OWN_DCACHE,
    OWN_PREFETCH
  } owner_t;

  typedef enum logic [2:0] {
    SD_IDLE,
    SD_WRITE,   // Serializing write beats.
    SD_WAIT,    // Read issued, no beat yet.
    SD_READ,
    SD_DONE
  } serdes_state_t;

  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_BUSY,
    ARB_HIT
  } arb_state_t;

endpackage

/* design/next_line_prefetcher.sv */
`timescale 1ns/1ns
`include "line_consts.svh"

module next_line_prefetcher (
  input  logic            clk,
  input  logic            rst,
  input  line_pkg::addr_t icache_addr,
  input  logic            icache_miss_grant,
  input  logic            pf_grant,
  input  logic            hit_served,
  input  logic            line_done,
  input  line_pkg::line_t rline,
  input  logic            wr_grant,
  input  line_pkg::addr_t write_addr,
  output logic            pf_req,
  output line_pkg::addr_t pf_addr,
  output logic            pf_hit,
  output line_pkg::line_t pf_line
);
  import line_pkg::*;

  line_tag_t icache_tag;
  line_tag_t write_tag;
  line_tag_t pf_tag;      // Line pending or held in the buffer.
  line_t     buf_line;
  logic      buf_valid;
  logic      track_next;
  logic      write_hit;

  assign icache_tag = icache_addr[`LINE_ADDR_W-1:`LINE_OFFSET_W];
  assign write_tag  = write_addr[`LINE_ADDR_W-1:`LINE_OFFSET_W];

  // Both a miss and a buffer hit move the window one line ahead.
  assign track_next = icache_miss_grant | hit_served;
  assign write_hit  = wr_grant && (write_tag == pf_tag);

  always_ff @(posedge clk) begin
    if (rst) begin
      pf_req    <= 1'b0;
      buf_valid <= 1'b0;
    end else if (track_next) begin
      pf_req    <= 1'b1;
      buf_valid <= 1'b0;
    end else if (write_hit) begin
      // Stale line, drop it and any pending fetch.
      pf_req    <= 1'b0;
      buf_valid <= 1'b0;
    end else begin
      if (pf_grant) begin
        pf_req <= 1'b0;
      end
      if (line_done) begin
        buf_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (track_next) begin
      pf_tag <= icache_tag + 1'b1;
    end
    if (line_done) begin
      buf_line <= rline;
    end
  end

  assign pf_addr = {pf_tag, {`LINE_OFFSET_W{1'b0}}};
  assign pf_hit  = buf_valid && (icache_tag == pf_tag);
  assign pf_line = buf_line;

  // The arbiter only serves hits out of a filled buffer.
  a_hit_needs_valid: assert property (@(posedge clk) disable iff (rst)
    hit_served |-> buf_valid)
    else $error("Prefetch hit with an empty buffer.");

endmodule

/* project.f */
+incdir+design
design/line_pkg.sv
design/line_arbiter.sv
design/next_line_prefetcher.sv
design/burst_serdes.sv
design/line_adapter_top.sv
sim/burst_mem_model.sv
sim/tb_line_adapter.sv

/* sim/burst_mem_model.sv */
`timescale 1ns/1ns
`include "line_consts.svh"

module burst_mem_model #(
  parameter line_pkg::beat_t FILL_KEY = 64'h0
) (
  input  logic            clk,
  input  logic            rst,
  input  line_pkg::addr_t bmem_addr,
  input  logic            bmem_read,
  input  logic            bmem_write,
  input  line_pkg::beat_t bmem_wdata,
  output logic            bmem_ready,
  output line_pkg::beat_t bmem_rdata,
  output logic            bmem_rvalid,
  input  logic            ready_stall,   // Random back-pressure on writes.
  input  logic            beat_gap       // Random hole in the read stream.
);
  import line_pkg::*;

  localparam int WORDS = 256;   // 64 lines of four beats.

  beat_t     mem [WORDS];
  addr_t     rd_base;
  beat_idx_t rd_beat;
  beat_idx_t wr_beat;
  logic      rd_busy;

  // Word slot of one beat inside the modeled window.
  function automatic int word_index(input addr_t base, input beat_idx_t beat);
    addr_t a;
    a = base + (addr_t'(beat) << 3);
    return int'(a[10:3]);
  endfunction

  initial begin
    for (int i = 0; i < WORDS; i++) begin
      mem[i] = beat_t'(addr_t'(i * 8)) ^ FILL_KEY;   // Beat byte address.
    end
  end

  assign bmem_ready = bmem_write && !ready_stall;

  always @(posedge clk) begin
    if (rst) begin
      rd_busy     <= 1'b0;
      rd_beat     <= '0;
      wr_beat     <= '0;
      bmem_rvalid <= 1'b0;
      bmem_rdata  <= '0;
    end else begin
      if (bmem_write && bmem_ready) begin
        mem[word_index(bmem_addr, wr_beat)] <= bmem_wdata;
        wr_beat <= wr_beat + 1'b1;   // Wraps after the fourth beat.
      end
      bmem_rvalid <= 1'b0;
      if (bmem_read) begin
        rd_base <= bmem_addr;
        rd_beat <= '0;
        rd_busy <= 1'b1;
      end else if (rd_busy && !beat_gap) begin
        bmem_rvalid <= 1'b1;
        bmem_rdata  <= mem[word_index(rd_base, rd_beat)];
        rd_beat     <= rd_beat + 1'b1;
        if (rd_beat == beat_idx_t'(`LINE_BEATS - 1)) begin
          rd_busy <= 1'b0;
        end
      end
    end
  end

endmodule

/* sim/tb_line_adapter.sv */
`timescale 1ns/1ns
`include "line_consts.svh"

module tb_line_adapter;
  import line_pkg::*;

  localparam int    NUM_ROWS    = 16;
  localparam int    LINES       = 64;    // Window the memory model covers.
  localparam int    QUIET_NEED  = 4;     // Idle bus cycles before a new row.
  localparam int    ROW_CYCLES  = 200;   // Worst case for one row, stalls included.
  localparam int    CYCLE_LIMIT = NUM_ROWS * ROW_CYCLES + 20;
  localparam beat_t FILL_KEY    = 64'h5a5a_c3c3_0ff0_9669;

  typedef struct packed {
    logic  dcache;   // Else instruction cache.
    logic  wr;
    addr_t addr;
    beat_t seed;     // Expanded into the write line.
    logic  both;     // Raised together with the next row.
    logic  hit;      // Must come from the prefetch buffer.
  } row_t;

  logic  clk, rst;
  logic  icache_read, icache_resp;
  addr_t icache_addr;
  line_t icache_rdata;
  logic  dcache_read, dcache_write, dcache_resp;
  addr_t dcache_addr;
  line_t dcache_wdata, dcache_rdata;
  addr_t bmem_addr;
  logic  bmem_read, bmem_write, bmem_ready, bmem_rvalid;
  beat_t bmem_wdata, bmem_rdata;
  logic  ready_stall, beat_gap;

  logic [15:0] lfsr;
  row_t  rows [NUM_ROWS];
  line_t shadow [LINES];
  int    errors, checks, cycles;
  int    read_count, open_beats, quiet;
  logic  last_dcache;   // Cache that held the bus last.
  int    r;

  line_adapter_top dut (
    .clk(clk), .rst(rst),
    .icache_read(icache_read), .icache_addr(icache_addr),
    .icache_rdata(icache_rdata), .icache_resp(icache_resp),
    .dcache_read(dcache_read), .dcache_write(dcache_write), .dcache_addr(dcache_addr),
    .dcache_wdata(dcache_wdata), .dcache_rdata(dcache_rdata), .dcache_resp(dcache_resp),
    .bmem_addr(bmem_addr), .bmem_read(bmem_read), .bmem_write(bmem_write),
    .bmem_wdata(bmem_wdata), .bmem_ready(bmem_ready), .bmem_rdata(bmem_rdata),
    .bmem_rvalid(bmem_rvalid)
  );

  burst_mem_model #(.FILL_KEY(FILL_KEY)) u_mem (
    .clk(clk), .rst(rst),
    .bmem_addr(bmem_addr), .bmem_read(bmem_read), .bmem_write(bmem_write),
    .bmem_wdata(bmem_wdata), .bmem_ready(bmem_ready), .bmem_rdata(bmem_rdata),
    .bmem_rvalid(bmem_rvalid), .ready_stall(ready_stall), .beat_gap(beat_gap)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Untouched memory, each beat is its byte address XOR the key.
  function automatic line_t rule_line(input int line_no);
    line_t l;
    addr_t a;
    for (int b = 0; b < `LINE_BEATS; b++) begin
      a = addr_t'((line_no << `LINE_OFFSET_W) + b * (`BEAT_W / 8));
      l[b*`BEAT_W +: `BEAT_W] = beat_t'(a) ^ FILL_KEY;
    end
    return l;
  endfunction

  function automatic line_t spread_seed(input beat_t seed);
    return {~seed, {seed[31:0], seed[63:32]}, seed + 64'd1, seed};
  endfunction

  // x^16 + x^14 + x^13 + x^11 + 1.
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic set_row(input int idx, input logic dc, input logic wr, input int line_no,
                         input beat_t seed, input logic both, input logic hit);
    rows[idx] = '{dcache: dc, wr: wr, addr: addr_t'(line_no << `LINE_OFFSET_W),
                  seed: seed, both: both, hit: hit};
  endtask

  task automatic raise_request(input int idx);
    if (rows[idx].dcache) begin
      dcache_addr  = rows[idx].addr;
      dcache_wdata = rows[idx].wr ? spread_seed(rows[idx].seed) : '0;
      dcache_read  = !rows[idx].wr;
      dcache_write = rows[idx].wr;
    end else begin
      icache_addr = rows[idx].addr;
      icache_read = 1'b1;
    end
  endtask

  task automatic retire_row(input int idx, input int waited, input int reads_before);
    line_t got;
    int    ln;
    ln = int'(rows[idx].addr >> `LINE_OFFSET_W);
    if (rows[idx].dcache) begin
      got          = dcache_rdata;
      dcache_read  = 1'b0;
      dcache_write = 1'b0;
    end else begin
      got         = icache_rdata;
      icache_read = 1'b0;
    end
    checks++;
    if (rows[idx].wr) begin
      shadow[ln] = spread_seed(rows[idx].seed);
    end else if (got !== shadow[ln]) begin
      errors++;
      $display("[FAIL] %s row %0d got %h expected %h",
               rows[idx].dcache ? "dcache_rdata" : "icache_rdata", idx, got, shadow[ln]);
    end
    if (rows[idx].hit && (waited != 1 || read_count != reads_before)) begin
      errors++;
      $display("Row %0d was not answered from the prefetch buffer in one cycle.", idx);
    end
    if (!rows[idx].hit && !rows[idx].wr && read_count == reads_before) begin
      errors++;
      $display("Row %0d was answered without any bus read.", idx);
    end
  endtask

  task automatic wait_quiet();
    repeat (QUIET_NEED) @(negedge clk);   // A follow-on prefetch needs a few cycles to start.
    while (quiet < QUIET_NEED) begin
      @(negedge clk);
    end
  endtask

  task automatic serve_rows(input int first, input int count);
    logic waiting [2];
    int   row_of [2];
    int   waited;
    int   reads_before;
    int   served;
    int   c;
    logic first_dcache;
    wait_quiet();
    first_dcache = ~last_dcache;   // A tie goes to the cache not served last.
    waiting[0]   = 1'b0;
    waiting[1]   = 1'b0;
    for (int k = 0; k < count; k++) begin
      raise_request(first + k);
      c          = rows[first+k].dcache;
      waiting[c] = 1'b1;
      row_of[c]  = first + k;
    end
    reads_before = read_count;
    waited       = 0;
    served       = 0;
    while (served < count) begin
      @(negedge clk);
      waited++;
      if (icache_resp || dcache_resp) begin
        c = dcache_resp;
        if (!waiting[c]) begin
          errors++;
          $display("Response from the %s cache with no request pending.",
                   c ? "data" : "instruction");
        end else begin
          checks++;
          if (count == 2 && served == 0 && c != first_dcache) begin
            errors++;
            $display("[FAIL] dcache_resp first in pair got %h expected %h", c, first_dcache);
          end
          retire_row(row_of[c], waited, reads_before);
          waiting[c]  = 1'b0;
          last_dcache = c;
          served++;
        end
      end
    end
  endtask

  // Bus activity, and how long the bus has been idle.
  always @(posedge clk) begin
    if (rst) begin
      read_count <= 0;
      open_beats <= 0;
      quiet      <= 0;
    end else begin
      if (bmem_read) begin
        read_count <= read_count + 1;
      end
      open_beats <= open_beats + (bmem_read ? `LINE_BEATS : 0) - (bmem_rvalid ? 1 : 0);
      if (bmem_read || bmem_write || bmem_rvalid || open_beats != 0) begin
        quiet <= 0;
      end else begin
        quiet <= quiet + 1;
      end
    end
  end

  always @(negedge clk) begin
    lfsr        = lfsr_next(lfsr);
    ready_stall = lfsr[0];
    lfsr        = lfsr_next(lfsr);
    beat_gap    = lfsr[0];
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Run stopped after %0d cycles without finishing the table.", cycles);
      $display("Errors: %0d of %0d checks.", errors, checks);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  initial begin
    lfsr         = 16'd31;
    rst          = 1'b1;
    icache_read  = 1'b0;
    icache_addr  = '0;
    dcache_read  = 1'b0;
    dcache_write = 1'b0;
    dcache_addr  = '0;
    dcache_wdata = '0;
    ready_stall  = 1'b0;
    beat_gap     = 1'b0;
    errors       = 0;
    checks       = 0;
    cycles       = 0;
    last_dcache  = 1'b1;
    for (int l = 0; l < LINES; l++) begin
      shadow[l] = rule_line(l);
    end
    set_row(0,  1'b1, 1'b1, 2,  64'h0123_4567_89ab_cdef, 1'b0, 1'b0);
    set_row(1,  1'b1, 1'b0, 2,  64'h0,                   1'b0, 1'b0);
    set_row(2,  1'b1, 1'b0, 9,  64'h0,                   1'b0, 1'b0);
    set_row(3,  1'b0, 1'b0, 4,  64'h0,                   1'b0, 1'b0);
    set_row(4,  1'b0, 1'b0, 5,  64'h0,                   1'b0, 1'b1);   // Prefetched.
    set_row(5,  1'b0, 1'b0, 6,  64'h0,                   1'b0, 1'b1);
    set_row(6,  1'b1, 1'b1, 7,  64'hfeed_0000_beef_0001, 1'b0, 1'b0);   // Kills buffer.
    set_row(7,  1'b0, 1'b0, 7,  64'h0,                   1'b0, 1'b0);
    set_row(8,  1'b0, 1'b0, 12, 64'h0,                   1'b0, 1'b0);
    set_row(9,  1'b0, 1'b0, 20, 64'h0,                   1'b1, 1'b0);
    set_row(10, 1'b1, 1'b1, 21, 64'h1357_9bdf_2468_ace0, 1'b0, 1'b0);
    set_row(11, 1'b1, 1'b0, 21, 64'h0,                   1'b0, 1'b0);
    set_row(12, 1'b0, 1'b0, 22, 64'h0,                   1'b1, 1'b0);
    set_row(13, 1'b1, 1'b0, 23, 64'h0,                   1'b0, 1'b0);
    set_row(14, 1'b1, 1'b1, 30, 64'h8421_0f0f_7777_3c3c, 1'b0, 1'b0);
    set_row(15, 1'b0, 1'b0, 2,  64'h0,                   1'b0, 1'b0);
    repeat (10) @(posedge clk);
    @(negedge clk);
    checks++;
    if ({icache_resp, dcache_resp, bmem_read, bmem_write} !== 4'h0) begin
      errors++;
      $display("[FAIL] {icache_resp,dcache_resp,bmem_read,bmem_write} got %h expected 0",
               {icache_resp, dcache_resp, bmem_read, bmem_write});
    end
    rst = 1'b0;
    r   = 0;
    while (r < NUM_ROWS) begin
      if (rows[r].both) begin
        serve_rows(r, 2);
        r = r + 2;
      end else begin
        serve_rows(r, 1);
        r = r + 1;
      end
    end
    $display("Errors: %0d of %0d checks, %0d bus reads.", errors, checks, read_count);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule
